/* rtl/alu_execute.sv */
module alu_execute (
	input logic clk,
	input logic n_reset,
	uop_if.sink uop,
	retire_if.source ret
);
	import cpu_pkg::*;

	logic [7:0] a, x, y, p;
	logic [7:0] ina, inb;
	logic cin;
	logic [8:0] sum, res;
	logic ovf;
	logic [7:0] a_new, x_new, y_new, p_new;
	logic flag_bit;
	logic accept;

	assign uop.ready = !ret.valid || ret.ready;
	assign accept = uop.valid && uop.ready;

	always_comb begin
		case (uop.src)
		SRC_A: ina = a;
		SRC_X: ina = x;
		SRC_Y: ina = y;
		default: ina = uop.b_operand;
		endcase
		// Subtract is an add of the inverted operand
		inb = (uop.op == ALU_SUB) ? ~uop.b_operand : uop.b_operand;
		case (uop.carry)
		CARRY_ZERO: cin = 1'b0;
		CARRY_ONE: cin = 1'b1;
		default: cin = p[FLAG_C];
		endcase
		sum = {1'b0, ina} + {1'b0, inb} + {8'd0, cin};
		ovf = ~(ina[7] ^ inb[7]) & (ina[7] ^ sum[7]);
		case (uop.op)
		ALU_AND: res = {1'b0, ina & inb};
		ALU_OR: res = {1'b0, ina | inb};
		ALU_EOR: res = {1'b0, ina ^ inb};
		ALU_SHL: res = {ina, cin};
		ALU_SHR: res = {ina[0], cin, ina[7:1]};
		ALU_PASS: res = {1'b0, ina};
		default: res = sum;
		endcase
	end

	always_comb begin
		a_new = |(uop.dst & DST_A) ? res[7:0] : a;
		x_new = |(uop.dst & DST_X) ? res[7:0] : x;
		y_new = |(uop.dst & DST_Y) ? res[7:0] : y;
		p_new = p;
		if (uop.flags inside {FLG_NZ, FLG_NZC, FLG_NVZC}) begin
			p_new[FLAG_N] = res[7];
			p_new[FLAG_Z] = (res[7:0] == 8'd0);
		end
		if (uop.flags inside {FLG_NZC, FLG_NVZC})
			p_new[FLAG_C] = res[8];
		if (uop.flags == FLG_NVZC)
			p_new[FLAG_V] = ovf;
		if (uop.flags == FLG_CLR_C)
			p_new[FLAG_C] = 1'b0;
		if (uop.flags == FLG_SET_C)
			p_new[FLAG_C] = 1'b1;
		if (uop.flags == FLG_CLR_V)
			p_new[FLAG_V] = 1'b0;
		p_new[FLAG_R] = 1'b1;
	end

	// Branch condition in N, V, C, Z order
	always_comb begin
		case (uop.flag_sel)
		2'd0: flag_bit = p[FLAG_N];
		2'd1: flag_bit = p[FLAG_V];
		2'd2: flag_bit = p[FLAG_C];
		default: flag_bit = p[FLAG_Z];
		endcase
	end

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset) begin
			a <= 8'h00;
			x <= 8'h00;
			y <= 8'h00;
			p <= 8'h20;
			ret.valid <= 1'b0;
		end else if (accept) begin
			a <= a_new;
			x <= x_new;
			y <= y_new;
			p <= p_new;
			ret.valid <= 1'b1;
		end else if (ret.ready) begin
			ret.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ret.a <= a_new;
			ret.x <= x_new;
			ret.y <= y_new;
			ret.p <= p_new;
			ret.taken <= uop.is_branch && (flag_bit == uop.cond);
			ret.length <= uop.length;
			ret.offset <= uop.offset;
		end
	end

endmodule

/* rtl/cpu_core.sv */
module cpu_core #(
	parameter logic [15:0] RESET_PC = 16'h0200
) (
	input logic clk,
	input logic n_reset,
	input logic op_valid,
	output logic op_ready,
	input logic [7:0] opcode,
	input logic [7:0] operand,
	output logic ret_valid,
	input logic ret_ready,
	output logic [15:0] ret_pc,
	output logic [7:0] ret_a,
	output logic [7:0] ret_x,
	output logic [7:0] ret_y,
	output logic [7:0] ret_p
);
	uop_if uop_bus ();
	retire_if ret_bus ();

	op_decode decode_i (
		.clk, .n_reset,
		.op_valid, .op_ready,
		.opcode, .operand,
		.uop(uop_bus.source)
	);

	alu_execute execute_i (
		.clk, .n_reset,
		.uop(uop_bus.sink),
		.ret(ret_bus.source)
	);

	retire_result #(.RESET_PC(RESET_PC)) result_i (
		.clk, .n_reset,
		.ret(ret_bus.sink),
		.ret_valid, .ret_ready,
		.ret_pc, .ret_a, .ret_x, .ret_y, .ret_p
	);

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

	// Standard aaabbbcc opcode layout
	typedef struct packed {
		logic [2:0] grp_a;
		logic [2:0] mode_b;
		logic [1:0] cls_c;
	} alu_form_t;

	// Relative branches are xxy10000
	typedef struct packed {
		logic [1:0] flag_sel;
		logic cond;
		logic [4:0] tag;
	} branch_form_t;

	typedef union packed {
		alu_form_t alu_form;
		branch_form_t branch_form;
	} opcode_t;

	localparam logic [4:0] BRANCH_TAG = 5'b10000;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_EOR, ALU_SHL, ALU_SHR, ALU_PASS
	} alu_op_e;

	typedef enum logic [1:0] {
		SRC_OPERAND, SRC_A, SRC_X, SRC_Y
	} src_e;

	typedef enum logic [1:0] {
		CARRY_ZERO, CARRY_ONE, CARRY_FLAG
	} carry_e;

	typedef enum logic [2:0] {
		FLG_NONE, FLG_NZ, FLG_NZC, FLG_NVZC, FLG_CLR_C, FLG_SET_C, FLG_CLR_V
	} flag_upd_e;

	// Write mask over A, X and Y
	typedef logic [2:0] dst_t;
	localparam dst_t DST_NONE = 3'b000;
	localparam dst_t DST_A = 3'b100;
	localparam dst_t DST_X = 3'b010;
	localparam dst_t DST_Y = 3'b001;

	// Status register bits
	localparam int FLAG_N = 7;
	localparam int FLAG_V = 6;
	localparam int FLAG_R = 5;
	localparam int FLAG_Z = 1;
	localparam int FLAG_C = 0;

endpackage

/* rtl/op_decode.sv */
module op_decode (
	input logic clk,
	input logic n_reset,
	input logic op_valid,
	output logic op_ready,
	input cpu_pkg::opcode_t opcode,
	input logic [7:0] operand,
	uop_if.source uop
);
	import cpu_pkg::*;

	alu_op_e d_op;
	src_e d_src;
	logic [7:0] d_b;
	carry_e d_carry;
	dst_t d_dst;
	flag_upd_e d_flags;
	logic d_branch;
	logic [1:0] d_len;
	logic [5:0] am;
	logic accept;

	assign am = {opcode.alu_form.grp_a, opcode.alu_form.mode_b};
	assign op_ready = !uop.valid || uop.ready;
	assign accept = op_valid && op_ready;

	always_comb begin
		// Anything not matched below is a one byte NOP
		d_op = ALU_PASS;
		d_src = SRC_OPERAND;
		d_b = operand;
		d_carry = CARRY_ZERO;
		d_dst = DST_NONE;
		d_flags = FLG_NONE;
		d_branch = 1'b0;
		d_len = 2'd1;
		if (opcode.branch_form.tag == BRANCH_TAG) begin
			d_branch = 1'b1;
			d_len = 2'd2;
		end else begin
			case (opcode.alu_form.cls_c)
			2'b01: if (opcode.alu_form.mode_b == 3'b010 && opcode.alu_form.grp_a != 3'b100) begin
				d_len = 2'd2;
				d_src = SRC_A;
				d_dst = DST_A;
				d_flags = FLG_NZ;
				case (opcode.alu_form.grp_a)
				3'b000: d_op = ALU_OR;
				3'b001: d_op = ALU_AND;
				3'b010: d_op = ALU_EOR;
				3'b011: begin
					d_op = ALU_ADD;
					d_carry = CARRY_FLAG;
					d_flags = FLG_NVZC;
				end
				3'b101: d_src = SRC_OPERAND;
				3'b110: begin
					// CMP keeps A
					d_op = ALU_SUB;
					d_carry = CARRY_ONE;
					d_dst = DST_NONE;
					d_flags = FLG_NZC;
				end
				default: begin
					d_op = ALU_SUB;
					d_carry = CARRY_FLAG;
					d_flags = FLG_NVZC;
				end
				endcase
			end
			2'b10: case (am)
			6'b101_000: {d_len, d_dst, d_flags} = {2'd2, DST_X, FLG_NZ};
			6'b000_010: {d_op, d_src, d_dst, d_flags} = {ALU_SHL, SRC_A, DST_A, FLG_NZC};
			6'b001_010: {d_op, d_src, d_carry, d_dst, d_flags} =
				{ALU_SHL, SRC_A, CARRY_FLAG, DST_A, FLG_NZC};
			6'b010_010: {d_op, d_src, d_dst, d_flags} = {ALU_SHR, SRC_A, DST_A, FLG_NZC};
			6'b011_010: {d_op, d_src, d_carry, d_dst, d_flags} =
				{ALU_SHR, SRC_A, CARRY_FLAG, DST_A, FLG_NZC};
			6'b100_010: {d_src, d_dst, d_flags} = {SRC_X, DST_A, FLG_NZ};
			6'b101_010: {d_src, d_dst, d_flags} = {SRC_A, DST_X, FLG_NZ};
			6'b110_010: {d_op, d_src, d_b, d_carry, d_dst, d_flags} =
				{ALU_SUB, SRC_X, 8'd1, CARRY_ONE, DST_X, FLG_NZ};
			default: ;
			endcase
			2'b00: case (am)
			6'b101_000: {d_len, d_dst, d_flags} = {2'd2, DST_Y, FLG_NZ};
			6'b100_010: {d_op, d_src, d_b, d_carry, d_dst, d_flags} =
				{ALU_SUB, SRC_Y, 8'd1, CARRY_ONE, DST_Y, FLG_NZ};
			6'b101_010: {d_src, d_dst, d_flags} = {SRC_A, DST_Y, FLG_NZ};
			6'b110_010: {d_op, d_src, d_b, d_carry, d_dst, d_flags} =
				{ALU_ADD, SRC_Y, 8'd0, CARRY_ONE, DST_Y, FLG_NZ};
			6'b111_010: {d_op, d_src, d_b, d_carry, d_dst, d_flags} =
				{ALU_ADD, SRC_X, 8'd0, CARRY_ONE, DST_X, FLG_NZ};
			6'b000_110: d_flags = FLG_CLR_C;
			6'b001_110: d_flags = FLG_SET_C;
			6'b100_110: {d_src, d_dst, d_flags} = {SRC_Y, DST_A, FLG_NZ};
			6'b101_110: d_flags = FLG_CLR_V;
			default: ;
			endcase
			default: ;
			endcase
		end
	end

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset)
			uop.valid <= 1'b0;
		else if (accept)
			uop.valid <= 1'b1;
		else if (uop.ready)
			uop.valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			uop.op <= d_op;
			uop.src <= d_src;
			uop.b_operand <= d_b;
			uop.carry <= d_carry;
			uop.dst <= d_dst;
			uop.flags <= d_flags;
			uop.is_branch <= d_branch;
			uop.flag_sel <= opcode.branch_form.flag_sel;
			uop.cond <= opcode.branch_form.cond;
			uop.length <= d_len;
			uop.offset <= operand;
		end
	end

endmodule

/* rtl/retire_result.sv */
module retire_result #(
	parameter logic [15:0] RESET_PC = 16'h0200
) (
	input logic clk,
	input logic n_reset,
	retire_if.sink ret,
	output logic ret_valid,
	input logic ret_ready,
	output logic [15:0] ret_pc,
	output logic [7:0] ret_a,
	output logic [7:0] ret_x,
	output logic [7:0] ret_y,
	output logic [7:0] ret_p
);
	logic [15:0] pc;
	logic [15:0] pc_seq, pc_next;
	logic accept;

	assign ret.ready = !ret_valid || ret_ready;
	assign accept = ret.valid && ret.ready;

	// Sign extended offset is added after the instruction length
	assign pc_seq = pc + {14'd0, ret.length};
	assign pc_next = ret.taken ? pc_seq + {{8{ret.offset[7]}}, ret.offset} : pc_seq;
	assign ret_pc = pc;

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset) begin
			pc <= RESET_PC;
			ret_valid <= 1'b0;
		end else if (accept) begin
			pc <= pc_next;
			ret_valid <= 1'b1;
		end else if (ret_ready) begin
			ret_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ret_a <= ret.a;
			ret_x <= ret.x;
			ret_y <= ret.y;
			ret_p <= ret.p;
		end
	end

endmodule

/* rtl/stage_ifs.sv */
interface uop_if;
	import cpu_pkg::*;

	logic valid, ready;
	alu_op_e op;
	src_e src;
	logic [7:0] b_operand;
	carry_e carry;
	dst_t dst;
	flag_upd_e flags;
	logic is_branch;
	logic [1:0] flag_sel;
	logic cond;
	logic [1:0] length;
	logic [7:0] offset;

	modport source (output valid, op, src, b_operand, carry, dst, flags,
		is_branch, flag_sel, cond, length, offset, input ready);
	modport sink (input valid, op, src, b_operand, carry, dst, flags,
		is_branch, flag_sel, cond, length, offset, output ready);
endinterface

interface retire_if;
	logic valid, ready;
	logic [7:0] a, x, y, p;
	logic taken;
	logic [1:0] length;
	logic [7:0] offset;

	modport source (output valid, a, x, y, p, taken, length, offset, input ready);
	modport sink (input valid, a, x, y, p, taken, length, offset, output ready);
endinterface

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module tb_cpu_core -f sources.f \
	&& ./obj_dir/Vtb_cpu_core > sim.log 2>&1 \
	|| { echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -qx "RESULT: PASS" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* sources.f */
+incdir+verification
rtl/cpu_pkg.sv
rtl/stage_ifs.sv
rtl/op_decode.sv
rtl/alu_execute.sv
rtl/retire_result.sv
rtl/cpu_core.sv
verification/tb_cpu_core.sv

/* verification/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Architectural state as it shows in a retire record
typedef struct packed {
	logic [15:0] pc;
	logic [7:0] a;
	logic [7:0] x;
	logic [7:0] y;
	logic [7:0] p;
} cpu_state_t;

function automatic logic [7:0] set_nz(logic [7:0] p, logic [7:0] val);
	logic [7:0] q;
	q = p;
	q[7] = val[7];
	q[1] = (val == 8'h00);
	return q;
endfunction

// Binary add that yields {V, C, sum}
function automatic logic [9:0] add_carry(logic [7:0] a, logic [7:0] b, logic c);
	logic [8:0] s;
	int sv;
	s = {1'b0, a} + {1'b0, b} + {8'd0, c};
	// Signed result out of range means overflow
	sv = int'($signed(a)) + int'($signed(b)) + int'(c);
	return {(sv > 127) || (sv < -128), s};
endfunction

function automatic logic branch_taken(logic [7:0] p, logic [7:0] opc);
	case (opc)
	8'h10: return !p[7];
	8'h30: return p[7];
	8'h50: return !p[6];
	8'h70: return p[6];
	8'h90: return !p[0];
	8'hB0: return p[0];
	8'hD0: return !p[1];
	8'hF0: return p[1];
	default: return 1'b0;
	endcase
endfunction

// State after one instruction
function automatic cpu_state_t exec_model(cpu_state_t s, logic [7:0] opc, logic [7:0] opd);
	cpu_state_t n;
	logic [9:0] r;
	n = s;
	r = '0;
	case (opc)
	8'h09: n.a = s.a | opd;
	8'h29: n.a = s.a & opd;
	8'h49: n.a = s.a ^ opd;
	8'hA9: n.a = opd;
	8'hA2: n.x = opd;
	8'hA0: n.y = opd;
	8'hAA: n.x = s.a;
	8'hA8: n.y = s.a;
	8'h8A: n.a = s.x;
	8'h98: n.a = s.y;
	8'hE8: n.x = s.x + 8'd1;
	8'hC8: n.y = s.y + 8'd1;
	8'hCA: n.x = s.x - 8'd1;
	8'h88: n.y = s.y - 8'd1;
	8'h18: n.p[0] = 1'b0;
	8'h38: n.p[0] = 1'b1;
	8'hB8: n.p[6] = 1'b0;
	8'h69: r = add_carry(s.a, opd, s.p[0]);
	8'hE9: r = add_carry(s.a, ~opd, s.p[0]);
	8'hC9: r = {1'b0, s.a >= opd, s.a - opd};
	8'h0A: r = {1'b0, s.a[7], s.a[6:0], 1'b0};
	8'h2A: r = {1'b0, s.a, s.p[0]};
	8'h4A: r = {1'b0, s.a[0], 1'b0, s.a[7:1]};
	8'h6A: r = {1'b0, s.a[0], s.p[0], s.a[7:1]};
	default: ;
	endcase
	if (opc inside {8'h69, 8'hE9})
		n.p[6] = r[9];
	if (opc inside {8'h69, 8'hE9, 8'h0A, 8'h2A, 8'h4A, 8'h6A})
		n.a = r[7:0];
	if (opc inside {8'h69, 8'hE9, 8'hC9, 8'h0A, 8'h2A, 8'h4A, 8'h6A})
		n.p[0] = r[8];
	// CMP sets N and Z from the difference only
	if (opc == 8'hC9)
		n.p = set_nz(n.p, r[7:0]);
	if (opc inside {8'h09, 8'h29, 8'h49, 8'hA9, 8'h8A, 8'h98,
			8'h69, 8'hE9, 8'h0A, 8'h2A, 8'h4A, 8'h6A})
		n.p = set_nz(n.p, n.a);
	if (opc inside {8'hA2, 8'hAA, 8'hE8, 8'hCA})
		n.p = set_nz(n.p, n.x);
	if (opc inside {8'hA0, 8'hA8, 8'hC8, 8'h88})
		n.p = set_nz(n.p, n.y);
	n.pc = s.pc + 16'd1;
	if (opc inside {8'h09, 8'h29, 8'h49, 8'h69, 8'hA9, 8'hC9, 8'hE9, 8'hA2, 8'hA0,
			8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0})
		n.pc = s.pc + 16'd2;
	if (branch_taken(s.p, opc))
		n.pc = n.pc + {{8{opd[7]}}, opd};
	return n;
endfunction

`endif

/* verification/tb_cpu_core.sv */
module tb_cpu_core;
	timeunit 1ns;
	timeprecision 100ps;

	`include "tb_model.svh"

	localparam logic [15:0] RESET_PC = 16'h0200;
	localparam int NUM_INSTR = 400;
	// Ten cycles per instruction
	localparam int MAX_CYCLES = NUM_INSTR * 10;
	localparam logic [7:0] OP_TABLE [33] = '{
		8'h69, 8'hE9, 8'hC9, 8'h29, 8'h09, 8'h49, 8'hA9, 8'hA2, 8'hA0,
		8'hAA, 8'h8A, 8'hA8, 8'h98, 8'hE8, 8'hC8, 8'hCA, 8'h88,
		8'h0A, 8'h4A, 8'h2A, 8'h6A, 8'h18, 8'h38, 8'hB8,
		8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0, 8'hEA
	};

	logic clk = 1'b0;
	logic n_reset;
	logic op_valid;
	logic op_ready;
	logic [7:0] opcode;
	logic [7:0] operand;
	logic ret_valid;
	logic ret_ready;
	logic [15:0] ret_pc;
	logic [7:0] ret_a, ret_x, ret_y, ret_p;

	integer seed = 20129;
	int issued = 0;
	int retired = 0;
	int cycles = 0;
	int value_errors = 0;
	int other_errors = 0;
	cpu_state_t model;
	cpu_state_t exp_rec;
	cpu_state_t expected_q [$];

	cpu_core dut_i (.*);

	always #2 clk = ~clk;

	initial begin
		logic [5:0] idx;
		n_reset <= 1'b0;
		op_valid <= 1'b0;
		opcode <= 8'hEA;
		operand <= 8'h00;
		ret_ready <= 1'b1;
		model = '{pc: RESET_PC, a: 8'h00, x: 8'h00, y: 8'h00, p: 8'h20};
		repeat (8) @(posedge clk);
		n_reset <= 1'b1;
		@(posedge clk);
		assert (!ret_valid && op_ready) else begin
			value_errors++;
			$display("ERR %0t: ret_valid %b op_ready %b after reset", $time, ret_valid, op_ready);
		end
		while (issued < NUM_INSTR) begin
			@(posedge clk);
			if (op_valid && op_ready) begin
				model = exec_model(model, opcode, operand);
				expected_q.push_back(model);
				issued++;
			end
			// Payload may only change once the previous one was taken
			if (!op_valid || op_ready) begin
				if (issued < NUM_INSTR && ($random(seed) & 3) != 0) begin
					idx = 6'($unsigned($random(seed)) % 33);
					opcode <= OP_TABLE[idx];
					operand <= 8'($random(seed));
					op_valid <= 1'b1;
				end else begin
					op_valid <= 1'b0;
				end
			end
			ret_ready <= ($random(seed) & 3) != 0;
		end
		ret_ready <= 1'b1;
		wait (retired >= NUM_INSTR);
		repeat (4) @(posedge clk);
		$display("Errors: %0d value, %0d other; %0d issued, %0d retired",
			value_errors, other_errors, issued, retired);
		if (value_errors == 0 && other_errors == 0 && expected_q.size() == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Retire records in issue order
	always @(posedge clk) begin
		if (n_reset && ret_valid && ret_ready) begin
			assert (expected_q.size() != 0) else begin
				other_errors++;
				$display("Retire at %0t with no instruction outstanding", $time);
			end
			if (expected_q.size() != 0) begin
				exp_rec = expected_q.pop_front();
				assert ({ret_pc, ret_a, ret_x, ret_y, ret_p} == exp_rec) else begin
					value_errors++;
					$display("ERR %0t: retire %0d pc %h a %h x %h y %h p %h, expected %h %h %h %h %h",
						$time, retired, ret_pc, ret_a, ret_x, ret_y, ret_p,
						exp_rec.pc, exp_rec.a, exp_rec.x, exp_rec.y, exp_rec.p);
				end
			end
			retired++;
		end
	end

	hold_while_stalled: assert property (@(posedge clk) disable iff (!n_reset)
		(ret_valid && !ret_ready) |=>
			(ret_valid && $stable({ret_pc, ret_a, ret_x, ret_y, ret_p})))
	else begin
		value_errors++;
		$display("ERR %0t: retire record changed while ret_ready was low", $time);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: only %0d of %0d instructions retired after %0d cycles",
				retired, NUM_INSTR, cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

endmodule
